/* include/bridge_consts.svh */
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// --------------------------------------------------
// Stream widths
// --------------------------------------------------
`define BRIDGE_DATA_W 64
// One keep bit per data byte
`define BRIDGE_KEEP_W 8

// --------------------------------------------------
// TLP decode
// --------------------------------------------------
// 3DW header with data
`define TLP_FMT_MWR32 3'b010
// Memory request type field
`define TLP_TYPE_MEM 5'b00000

// --------------------------------------------------
// Snoop encapsulation
// --------------------------------------------------
`define SNOOP_HDR_BEATS 6
// Ethernet 14 + IPv4 20 + UDP 8 + magic 4 + pad 2
`define SNOOP_HDR_BYTES 48
`define ETH_TYPE_IPV4 16'h0800
`define IP_PROTO_UDP 8'h11
`define IP_TTL_DEFAULT 8'h40

// --------------------------------------------------
// Register block
// --------------------------------------------------
`define WB_ADDR_W 4
`define CFG_REG_COUNT 10

`endif

/* rtl/bridge_pkg.sv */
`include "bridge_consts.svh"

package bridge_pkg;

  // --------------------------------------------------
  // Stream beat
  // --------------------------------------------------
  // Byte 0 of the stream sits in data[7:0]
  typedef struct packed {
    logic [`BRIDGE_DATA_W-1:0] data;
    logic [`BRIDGE_KEEP_W-1:0] keep;
    logic                      last;
  } stream_beat_t;

  // --------------------------------------------------
  // First beat of a TLP
  // --------------------------------------------------
  // DW0 in the low half, DW1 in the high half
  typedef struct packed {
    // DW1
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [3:0]  last_be;
    logic [3:0]  first_be;
    // DW0 upper half
    logic [2:0]  fmt;
    logic [4:0]  tlp_type;
    logic        rsvd_a;
    logic [2:0]  tc;
    // Attr2, TH and reserved bits
    logic [3:0]  rsvd_b;
    // DW0 lower half
    logic        td;
    logic        ep;
    logic [1:0]  attr;
    logic [1:0]  at;
    // Payload size in dwords
    logic [9:0]  length;
  } tlp_hdr_t;

  // Same word seen as header fields or as plain data
  typedef union packed {
    logic [`BRIDGE_DATA_W-1:0] raw;
    tlp_hdr_t                  hdr;
  } tlp_first_beat_u;

  // --------------------------------------------------
  // Encapsulation fields from the register block
  // --------------------------------------------------
  typedef struct packed {
    logic [31:0] magic;
    logic [47:0] dstmac;
    logic [47:0] srcmac;
    logic [31:0] dstip;
    logic [31:0] srcip;
    logic [15:0] dstport;
    logic [15:0] srcport;
  } snoop_cfg_t;

  // --------------------------------------------------
  // Wishbone classic request from the host
  // --------------------------------------------------
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [31:0]           dat;
  } wb_req_t;

endpackage

/* rtl/pcie_rx_filter.sv */
`include "bridge_consts.svh"

module pcie_rx_filter (
  input  logic                     user_clk,
  input  logic                     sys_rst_n_c,
  input  bridge_pkg::stream_beat_t tlp_in,
  input  logic                     tlp_in_valid,
  output logic                     tlp_in_ready,
  output bridge_pkg::stream_beat_t app_out,
  output logic                     app_out_valid,
  input  logic                     app_out_ready,
  output bridge_pkg::stream_beat_t snoop_beat,
  output logic                     snoop_valid,
  input  logic                     snoop_ready
);

  // Header view of the incoming word
  bridge_pkg::tlp_first_beat_u first_beat;
  logic is_mwr;
  // Mid-packet flag and the side picked on the first beat
  logic in_pkt;
  logic route_q;
  logic sel_snoop;
  logic app_free;
  logic snoop_free;
  // Input stays closed for the first cycle out of reset
  logic in_en;
  logic accept;

  // --------------------------------------------------
  // Classification
  // --------------------------------------------------
  assign first_beat = tlp_in.data;

  // Only 3DW memory writes are snooped
  assign is_mwr = (first_beat.hdr.fmt == `TLP_FMT_MWR32) &&
                  (first_beat.hdr.tlp_type == `TLP_TYPE_MEM);

  // Later beats follow the first one
  assign sel_snoop = in_pkt ? route_q : is_mwr;

  // Output register can take a beat
  assign app_free   = !app_out_valid || app_out_ready;
  assign snoop_free = !snoop_valid || snoop_ready;

  assign tlp_in_ready = in_en && (sel_snoop ? snoop_free : app_free);
  assign accept       = tlp_in_valid && tlp_in_ready;

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge user_clk) begin
    if (!sys_rst_n_c) begin
      in_en         <= 1'b0;
      in_pkt        <= 1'b0;
      route_q       <= 1'b0;
      app_out_valid <= 1'b0;
      snoop_valid   <= 1'b0;
    end else begin
      in_en <= 1'b1;
      // Drain on downstream ready
      if (app_out_ready) begin
        app_out_valid <= 1'b0;
      end
      if (snoop_ready) begin
        snoop_valid <= 1'b0;
      end
      if (accept) begin
        in_pkt  <= !tlp_in.last;
        route_q <= sel_snoop;
        if (sel_snoop) begin
          snoop_valid <= 1'b1;
        end else begin
          app_out_valid <= 1'b1;
        end
      end
    end
  end

  // Beat registers, loaded only on accept
  always_ff @(posedge user_clk) begin
    if (accept && sel_snoop) begin
      snoop_beat <= tlp_in;
    end
    if (accept && !sel_snoop) begin
      app_out <= tlp_in;
    end
  end

  // Packet stays on one side until its last beat
  a_route_held: assert property (
    @(posedge user_clk) disable iff (!sys_rst_n_c)
    in_pkt && !(accept && tlp_in.last) |=> in_pkt && $stable(route_q)
  );

endmodule

/* rtl/snoop_cfg_regs.sv */
`include "bridge_consts.svh"

module snoop_cfg_regs (
  input  logic                   user_clk,
  input  logic                   sys_rst_n_c,
  input  bridge_pkg::wb_req_t    wb_req,
  output logic [31:0]            wb_dat,
  output logic                   wb_ack,
  input  logic                   frame_done,
  output bridge_pkg::snoop_cfg_t snoop_cfg
);

  // Frame counter sits at the top of the map
  localparam logic [`WB_ADDR_W-1:0] cnt_addr = `WB_ADDR_W'(`CFG_REG_COUNT - 1);

  bridge_pkg::snoop_cfg_t cfg_q;
  logic [31:0] frame_cnt;
  logic [31:0] rd_word;
  // New request, not yet acknowledged
  logic wb_hit;

  assign wb_hit    = wb_req.cyc && wb_req.stb && !wb_ack;
  assign snoop_cfg = cfg_q;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    case (wb_req.adr)
      4'd0:     rd_word = cfg_q.magic;
      // MAC high parts are right aligned
      4'd1:     rd_word = {16'h0000, cfg_q.dstmac[47:32]};
      4'd2:     rd_word = cfg_q.dstmac[31:0];
      4'd3:     rd_word = {16'h0000, cfg_q.srcmac[47:32]};
      4'd4:     rd_word = cfg_q.srcmac[31:0];
      4'd5:     rd_word = cfg_q.dstip;
      4'd6:     rd_word = cfg_q.srcip;
      4'd7:     rd_word = {16'h0000, cfg_q.dstport};
      4'd8:     rd_word = {16'h0000, cfg_q.srcport};
      cnt_addr: rd_word = frame_cnt;
      // Unmapped reads as zero
      default:  rd_word = 32'h0000_0000;
    endcase
  end

  // --------------------------------------------------
  // Registers, ack and counter
  // --------------------------------------------------
  always_ff @(posedge user_clk) begin
    if (!sys_rst_n_c) begin
      wb_ack    <= 1'b0;
      cfg_q     <= '0;
      frame_cnt <= 32'd0;
    end else begin
      // Single-cycle ack
      wb_ack <= wb_hit;
      if (frame_done) begin
        frame_cnt <= frame_cnt + 32'd1;
      end
      if (wb_hit && wb_req.we) begin
        case (wb_req.adr)
          4'd0: cfg_q.magic          <= wb_req.dat;
          4'd1: cfg_q.dstmac[47:32]  <= wb_req.dat[15:0];
          4'd2: cfg_q.dstmac[31:0]   <= wb_req.dat;
          4'd3: cfg_q.srcmac[47:32]  <= wb_req.dat[15:0];
          4'd4: cfg_q.srcmac[31:0]   <= wb_req.dat;
          4'd5: cfg_q.dstip          <= wb_req.dat;
          4'd6: cfg_q.srcip          <= wb_req.dat;
          4'd7: cfg_q.dstport        <= wb_req.dat[15:0];
          4'd8: cfg_q.srcport        <= wb_req.dat[15:0];
          // Counter and higher addresses drop writes
          default: ;
        endcase
      end
    end
  end

  // Read data captured with the request, shown with ack
  always_ff @(posedge user_clk) begin
    if (wb_hit) begin
      wb_dat <= rd_word;
    end
  end

  // Each request gets exactly one ack cycle
  a_ack_pulse: assert property (
    @(posedge user_clk) disable iff (!sys_rst_n_c)
    wb_hit |=> wb_ack ##1 !wb_ack
  );

endmodule

/* rtl/tlp_snoop_framer.sv */
`include "bridge_consts.svh"

module tlp_snoop_framer (
  input  logic                     user_clk,
  input  logic                     sys_rst_n_c,
  input  bridge_pkg::stream_beat_t snoop_beat,
  input  logic                     snoop_valid,
  output logic                     snoop_ready,
  input  bridge_pkg::snoop_cfg_t   snoop_cfg,
  output bridge_pkg::stream_beat_t eth_out,
  output logic                     eth_out_valid,
  input  logic                     eth_out_ready,
  output logic                     frame_done
);

  localparam int hdr_w = `SNOOP_HDR_BYTES * 8;
  localparam logic [2:0] last_hdr = 3'(`SNOOP_HDR_BEATS - 1);
  // 3DW TLP header size
  localparam logic [15:0] tlp_hdr_bytes = 16'd12;
  // IPv4 + UDP + magic + pad ahead of the TLP
  localparam logic [15:0] ip_extra = 16'd34;
  // UDP + magic + pad ahead of the TLP
  localparam logic [15:0] udp_extra = 16'd14;

  typedef enum logic [1:0] {
    st_idle,
    st_hdr,
    st_body
  } state_t;

  state_t state;
  logic [2:0] hdr_cnt;
  // Length field of the TLP being framed
  logic [9:0] tlp_len_q;
  bridge_pkg::tlp_first_beat_u first_beat;
  logic [15:0] tlp_bytes;
  logic [15:0] ip_len;
  logic [15:0] udp_len;
  logic [hdr_w-1:0] hdr_bytes;
  logic [63:0] hdr_word;
  bridge_pkg::stream_beat_t hdr_beat;
  logic out_free;
  logic body_move;

  // --------------------------------------------------
  // Length fields
  // --------------------------------------------------
  assign first_beat = snoop_beat.data;

  // 12 header bytes plus 4 per payload dword
  assign tlp_bytes = tlp_hdr_bytes + {4'h0, tlp_len_q, 2'b00};
  assign ip_len    = ip_extra + tlp_bytes;
  assign udp_len   = udp_extra + tlp_bytes;

  // --------------------------------------------------
  // Header image, first wire byte at the top
  // --------------------------------------------------
  assign hdr_bytes = {
    // Ethernet
    snoop_cfg.dstmac,
    snoop_cfg.srcmac,
    `ETH_TYPE_IPV4,
    // IPv4, version 4 IHL 5, TOS 0
    8'h45,
    8'h00,
    ip_len,
    // ID zero, DF set
    16'h0000,
    16'h4000,
    `IP_TTL_DEFAULT,
    `IP_PROTO_UDP,
    // Checksum left at zero
    16'h0000,
    snoop_cfg.srcip,
    snoop_cfg.dstip,
    // UDP, checksum zero
    snoop_cfg.srcport,
    snoop_cfg.dstport,
    udp_len,
    16'h0000,
    // Magic and two pad bytes
    snoop_cfg.magic,
    16'h0000
  };

  // Eight header bytes for the current beat
  assign hdr_word = hdr_bytes[hdr_w - 1 - 64 * hdr_cnt -: 64];

  // Lowest lane carries the earliest byte
  always_comb begin
    for (int i = 0; i < `BRIDGE_KEEP_W; i++) begin
      hdr_beat.data[8*i +: 8] = hdr_word[63 - 8*i -: 8];
    end
    hdr_beat.keep = '1;
    hdr_beat.last = 1'b0;
  end

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  assign out_free = !eth_out_valid || eth_out_ready;

  // TLP input only opens once the header is out
  assign snoop_ready = (state == st_body) && out_free;
  assign body_move   = snoop_valid && snoop_ready;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge user_clk) begin
    if (!sys_rst_n_c) begin
      state         <= st_idle;
      hdr_cnt       <= 3'd0;
      eth_out_valid <= 1'b0;
      frame_done    <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (eth_out_ready) begin
        eth_out_valid <= 1'b0;
      end
      case (state)
        st_idle: begin
          // First TLP beat waits at the input
          if (snoop_valid) begin
            state   <= st_hdr;
            hdr_cnt <= 3'd0;
          end
        end
        st_hdr: begin
          if (out_free) begin
            eth_out_valid <= 1'b1;
            hdr_cnt       <= hdr_cnt + 3'd1;
            if (hdr_cnt == last_hdr) begin
              state <= st_body;
            end
          end
        end
        st_body: begin
          if (body_move) begin
            eth_out_valid <= 1'b1;
            // End of frame
            if (snoop_beat.last) begin
              frame_done <= 1'b1;
              state      <= st_idle;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Length capture and output beat register
  always_ff @(posedge user_clk) begin
    if (state == st_idle && snoop_valid) begin
      tlp_len_q <= first_beat.hdr.length;
    end
    if (state == st_hdr && out_free) begin
      eth_out <= hdr_beat;
    end else if (body_move) begin
      eth_out <= snoop_beat;
    end
  end

  // Stalled beat is held unchanged
  a_out_stable: assert property (
    @(posedge user_clk) disable iff (!sys_rst_n_c)
    eth_out_valid && !eth_out_ready |=> eth_out_valid && $stable(eth_out)
  );

endmodule

/* rtl/pcie_eth_bridge.sv */
module pcie_eth_bridge (
  input  logic                     user_clk,
  input  logic                     sys_rst_n_c,
  // Receive TLPs
  input  bridge_pkg::stream_beat_t tlp_in,
  input  logic                     tlp_in_valid,
  output logic                     tlp_in_ready,
  // Non-snooped TLPs
  output bridge_pkg::stream_beat_t app_out,
  output logic                     app_out_valid,
  input  logic                     app_out_ready,
  // Ethernet frames
  output bridge_pkg::stream_beat_t eth_out,
  output logic                     eth_out_valid,
  input  logic                     eth_out_ready,
  // Host register access
  input  bridge_pkg::wb_req_t      wb_req,
  output logic [31:0]              wb_dat,
  output logic                     wb_ack
);

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------
  bridge_pkg::stream_beat_t snoop_beat;
  logic snoop_valid;
  logic snoop_ready;
  bridge_pkg::snoop_cfg_t snoop_cfg;
  logic frame_done;

  // Splits receive traffic
  pcie_rx_filter u_filter (
    .user_clk      (user_clk),
    .sys_rst_n_c   (sys_rst_n_c),
    .tlp_in        (tlp_in),
    .tlp_in_valid  (tlp_in_valid),
    .tlp_in_ready  (tlp_in_ready),
    .app_out       (app_out),
    .app_out_valid (app_out_valid),
    .app_out_ready (app_out_ready),
    .snoop_beat    (snoop_beat),
    .snoop_valid   (snoop_valid),
    .snoop_ready   (snoop_ready)
  );

  // Header fields and frame count
  snoop_cfg_regs u_regs (
    .user_clk    (user_clk),
    .sys_rst_n_c (sys_rst_n_c),
    .wb_req      (wb_req),
    .wb_dat      (wb_dat),
    .wb_ack      (wb_ack),
    .frame_done  (frame_done),
    .snoop_cfg   (snoop_cfg)
  );

  // Wraps memory writes into UDP frames
  tlp_snoop_framer u_framer (
    .user_clk      (user_clk),
    .sys_rst_n_c   (sys_rst_n_c),
    .snoop_beat    (snoop_beat),
    .snoop_valid   (snoop_valid),
    .snoop_ready   (snoop_ready),
    .snoop_cfg     (snoop_cfg),
    .eth_out       (eth_out),
    .eth_out_valid (eth_out_valid),
    .eth_out_ready (eth_out_ready),
    .frame_done    (frame_done)
  );

endmodule

/* verif/tb_pcie_eth_bridge.sv */
`include "bridge_consts.svh"

module tb_pcie_eth_bridge;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int drive_delay = 2;
  // Cycle limits for each kind of wait
  localparam int wb_limit    = 20;
  localparam int stall_limit = 400;
  localparam int drain_limit = 2000;

  logic                     user_clk;
  logic                     sys_rst_n_c;
  bridge_pkg::stream_beat_t tlp_in;
  logic                     tlp_in_valid;
  logic                     tlp_in_ready;
  bridge_pkg::stream_beat_t app_out;
  logic                     app_out_valid;
  logic                     app_out_ready;
  bridge_pkg::stream_beat_t eth_out;
  logic                     eth_out_valid;
  logic                     eth_out_ready;
  bridge_pkg::wb_req_t      wb_req;
  logic [31:0]              wb_dat;
  logic                     wb_ack;

  // Vector memory and read pointer
  logic [31:0] vec [0:1023];
  int vp;
  // Register shadow for addresses 0 to 15
  logic [31:0] shadow [0:15];
  int frames_exp;
  // Expected beats per output in order
  bridge_pkg::stream_beat_t app_q [$];
  bridge_pkg::stream_beat_t eth_q [$];
  logic [31:0] lfsr;
  logic bp_on;
  logic bp_seen;
  logic rst_seen;
  bit aborted;
  int value_errs;
  int proto_errs;
  int timeout_errs;

  pcie_eth_bridge uut (
    .user_clk      (user_clk),
    .sys_rst_n_c   (sys_rst_n_c),
    .tlp_in        (tlp_in),
    .tlp_in_valid  (tlp_in_valid),
    .tlp_in_ready  (tlp_in_ready),
    .app_out       (app_out),
    .app_out_valid (app_out_valid),
    .app_out_ready (app_out_ready),
    .eth_out       (eth_out),
    .eth_out_valid (eth_out_valid),
    .eth_out_ready (eth_out_ready),
    .wb_req        (wb_req),
    .wb_dat        (wb_dat),
    .wb_ack        (wb_ack)
  );

  // --------------------------------------------------
  // 40 ns clock
  // --------------------------------------------------
  initial begin
    user_clk = 1'b0;
    forever #20 user_clk = ~user_clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    lfsr_step = {s[30:0], fb};
  endfunction

  function automatic logic [31:0] next_word();
    next_word = vec[vp];
    vp++;
  endfunction

  // Read value from the register map rules
  function automatic logic [31:0] reg_expect(input int adr);
    case (adr)
      0, 2, 4, 5, 6: reg_expect = shadow[adr];
      // 16-bit fields read back zero-extended
      1, 3, 7, 8: reg_expect = {16'h0000, shadow[adr][15:0]};
      `CFG_REG_COUNT - 1: reg_expect = frames_exp;
      default: reg_expect = 32'h0000_0000;
    endcase
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_beat(input string name, input bridge_pkg::stream_beat_t got,
                            input bridge_pkg::stream_beat_t exp);
    if (got !== exp) begin
      $display("Error %s: got data %h keep %h last %h, expected data %h keep %h last %h",
               name, got.data, got.keep, got.last, exp.data, exp.keep, exp.last);
      value_errs++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error %s: got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  // --------------------------------------------------
  // Output ready driver
  // --------------------------------------------------
  always @(posedge user_clk) begin
    // Mode as seen at the edge
    rst_seen = sys_rst_n_c;
    bp_seen  = bp_on;
    #drive_delay;
    if (!rst_seen) begin
      app_out_ready = 1'b0;
      eth_out_ready = 1'b0;
    end else if (bp_seen) begin
      // Two bits per ready so it is high about three cycles in four
      lfsr = lfsr_step(lfsr);
      app_out_ready = lfsr[0];
      lfsr = lfsr_step(lfsr);
      app_out_ready = app_out_ready | lfsr[0];
      lfsr = lfsr_step(lfsr);
      eth_out_ready = lfsr[0];
      lfsr = lfsr_step(lfsr);
      eth_out_ready = eth_out_ready | lfsr[0];
    end else begin
      app_out_ready = 1'b1;
      eth_out_ready = 1'b1;
    end
  end

  // --------------------------------------------------
  // Output monitors sampled mid-cycle
  // --------------------------------------------------
  always @(negedge user_clk) begin
    if (sys_rst_n_c && app_out_valid && app_out_ready) begin
      if (app_q.size() == 0) begin
        $display("Unexpected beat on app_out with data %h", app_out.data);
        proto_errs++;
      end else begin
        check_beat("app_out", app_out, app_q.pop_front());
      end
    end
    if (sys_rst_n_c && eth_out_valid && eth_out_ready) begin
      if (eth_q.size() == 0) begin
        $display("Unexpected beat on eth_out with data %h", eth_out.data);
        proto_errs++;
      end else begin
        check_beat("eth_out", eth_out, eth_q.pop_front());
      end
    end
  end

  // --------------------------------------------------
  // Wishbone host
  // --------------------------------------------------
  task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                          output logic [31:0] rdata);
    int wait_cnt;
    bit got_ack;
    wait_cnt = 0;
    got_ack  = 0;
    rdata    = 32'h0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    while (!got_ack && wait_cnt < wb_limit) begin
      @(negedge user_clk);
      wait_cnt++;
      if (wb_ack) begin
        got_ack = 1;
        rdata   = wb_dat;
      end
    end
    @(posedge user_clk);
    #drive_delay;
    wb_req = '0;
    if (!got_ack) begin
      $display("Wishbone request to address %0d got no ack", adr);
      timeout_errs++;
      aborted = 1;
    end else begin
      // Request is sampled on the first edge and ack shows one cycle later
      if (wait_cnt != 2) begin
        $display("Wishbone ack at address %0d came %0d cycles after the request",
                 adr, wait_cnt - 1);
        proto_errs++;
      end
      @(negedge user_clk);
      if (wb_ack) begin
        $display("Wishbone ack at address %0d lasted more than one cycle", adr);
        proto_errs++;
      end
      @(posedge user_clk);
      #drive_delay;
    end
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
    // Counter and unmapped addresses keep their value
    if (adr < `CFG_REG_COUNT - 1) begin
      shadow[adr] = dat;
    end
  endtask

  // Read back the whole map including unmapped addresses
  task automatic check_regs();
    logic [31:0] rdata;
    for (int a = 0; a < 16 && !aborted; a++) begin
      wb_cycle(1'b0, a[3:0], 32'h0, rdata);
      if (!aborted) begin
        check_word($sformatf("wb_dat at address %0d", a), rdata, reg_expect(a));
      end
    end
  endtask

  // --------------------------------------------------
  // Reference header of six beats
  // --------------------------------------------------
  task automatic push_header(input logic [9:0] len);
    logic [7:0] hb [0:47];
    logic [15:0] tlp_bytes;
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    logic [47:0] dmac;
    logic [47:0] smac;
    bridge_pkg::stream_beat_t beat;
    tlp_bytes = 16'd12 + 16'd4 * len;
    ip_len    = 16'd34 + tlp_bytes;
    udp_len   = 16'd14 + tlp_bytes;
    dmac = {shadow[1][15:0], shadow[2]};
    smac = {shadow[3][15:0], shadow[4]};
    for (int i = 0; i < 48; i++) begin
      hb[i] = 8'h00;
    end
    for (int i = 0; i < 6; i++) begin
      hb[i]     = dmac[47 - 8*i -: 8];
      hb[6 + i] = smac[47 - 8*i -: 8];
    end
    {hb[12], hb[13]} = `ETH_TYPE_IPV4;
    // Version 4 and IHL 5
    hb[14] = 8'h45;
    {hb[16], hb[17]} = ip_len;
    // DF set and no fragments
    hb[20] = 8'h40;
    hb[22] = `IP_TTL_DEFAULT;
    hb[23] = `IP_PROTO_UDP;
    for (int i = 0; i < 4; i++) begin
      hb[26 + i] = shadow[6][31 - 8*i -: 8];
      hb[30 + i] = shadow[5][31 - 8*i -: 8];
      hb[42 + i] = shadow[0][31 - 8*i -: 8];
    end
    {hb[34], hb[35]} = shadow[8][15:0];
    {hb[36], hb[37]} = shadow[7][15:0];
    {hb[38], hb[39]} = udp_len;
    // Earliest byte in the lowest lane
    for (int b = 0; b < `SNOOP_HDR_BEATS; b++) begin
      for (int i = 0; i < 8; i++) begin
        beat.data[8*i +: 8] = hb[8*b + i];
      end
      beat.keep = 8'hff;
      beat.last = 1'b0;
      eth_q.push_back(beat);
    end
  endtask

  // --------------------------------------------------
  // TLP driver
  // --------------------------------------------------
  task automatic send_tlp(input logic route);
    logic [31:0] dws [0:63];
    bridge_pkg::stream_beat_t beats [0:31];
    int ndw;
    int nbeats;
    int wait_cnt;
    bit moved;
    ndw = next_word();
    if (ndw < 1 || ndw > 64) begin
      $display("TLP record at word %0d has a bad dword count %0d", vp - 1, ndw);
      proto_errs++;
      aborted = 1;
      return;
    end
    for (int i = 0; i < ndw; i++) begin
      dws[i] = next_word();
    end
    // DW0 in the low half and DW1 in the high half
    nbeats = (ndw + 1) / 2;
    for (int k = 0; k < nbeats; k++) begin
      beats[k].data[31:0]  = dws[2*k];
      beats[k].data[63:32] = (2*k + 1 < ndw) ? dws[2*k + 1] : 32'h0;
      beats[k].keep        = (2*k + 1 < ndw) ? 8'hff : 8'h0f;
      beats[k].last        = (k == nbeats - 1);
    end
    if (route) begin
      push_header(dws[0][9:0]);
      frames_exp++;
    end
    for (int k = 0; k < nbeats; k++) begin
      if (route) begin
        eth_q.push_back(beats[k]);
      end else begin
        app_q.push_back(beats[k]);
      end
    end
    for (int k = 0; k < nbeats && !aborted; k++) begin
      tlp_in       = beats[k];
      tlp_in_valid = 1'b1;
      moved    = 0;
      wait_cnt = 0;
      while (!moved && wait_cnt < stall_limit) begin
        @(negedge user_clk);
        moved = tlp_in_ready;
        wait_cnt++;
        @(posedge user_clk);
        #drive_delay;
      end
      if (!moved) begin
        $display("tlp_in stalled on beat %0d of a TLP with DW0 %h", k, dws[0]);
        timeout_errs++;
        aborted = 1;
      end
    end
    tlp_in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int wait_cnt;
    wait_cnt = 0;
    while ((app_q.size() != 0 || eth_q.size() != 0) && wait_cnt < drain_limit) begin
      @(posedge user_clk);
      #drive_delay;
      wait_cnt++;
    end
    if (app_q.size() != 0 || eth_q.size() != 0) begin
      $display("Outputs did not drain, %0d app beats and %0d eth beats still missing",
               app_q.size(), eth_q.size());
      timeout_errs++;
      aborted = 1;
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] kind;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    bit done;
    tlp_in        = '0;
    tlp_in_valid  = 1'b0;
    app_out_ready = 1'b0;
    eth_out_ready = 1'b0;
    wb_req        = '0;
    sys_rst_n_c   = 1'b0;
    lfsr          = 32'h4866;
    bp_on         = 1'b0;
    vp            = 0;
    frames_exp    = 0;
    done          = 0;
    for (int a = 0; a < 16; a++) begin
      shadow[a] = 32'h0;
    end
    $readmemh("verif/snoop_vectors.txt", vec);

    // Ten cycles of reset with outputs checked near the end
    repeat (9) @(posedge user_clk);
    @(negedge user_clk);
    check_word("valid, ready and ack in reset",
               {28'h0, app_out_valid, eth_out_valid, tlp_in_ready, wb_ack}, 32'h0);
    @(posedge user_clk);
    #drive_delay;
    sys_rst_n_c = 1'b1;

    while (!aborted && !done) begin
      kind = next_word();
      case (kind)
        32'd0: done = 1;
        32'd1: begin
          arg_a = next_word();
          arg_b = next_word();
          wb_write(arg_a[3:0], arg_b);
        end
        32'd2: check_regs();
        32'd3: begin
          arg_a = next_word();
          bp_on = arg_a[0];
        end
        32'd4: begin
          arg_a = next_word();
          send_tlp(arg_a[0]);
        end
        32'd5: wait_drain();
        default: begin
          $display("Vector file has an unknown record kind %h at word %0d", kind, vp - 1);
          proto_errs++;
          aborted = 1;
        end
      endcase
    end

    // Quiet tail to catch stray beats
    repeat (20) @(posedge user_clk);
    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verif/snoop_vectors.txt */
// Records: 1 adr dat = write, 2 = read back all 16 addresses, 3 on = back-pressure, 5 = drain
// 4 route ndw dw... = TLP with route 1 snoop 0 app, ndw header plus payload dwords, 0 = end
1 0 cafef00d
1 1 ffffa1b2
1 2 c3d4e5f6
1 3 00000a0b
1 4 0c0d0e0f
1 5 c0a80102
1 6 c0a80101
1 7 00001234
1 8 00005678
1 c deadbeef
1 9 00000077
2
4 0 3 00000004 0100000f 80001000
4 0 4 4a000001 01000004 02000010 11223344
4 1 5 40000002 010000ff 80002000 a5a5a5a5 5a5a5a5a
5
3 1
4 1 6 40000003 0100100f 80003000 00000001 00000002 00000003
4 0 3 00000001 0100200f 80004000
4 1 4 40000001 0100300f 80005000 deadbeef
4 0 5 60000001 0100400f 00000001 80006000 12345678
4 0 5 4a000002 01000008 02000020 aaaa5555 5555aaaa
4 1 7 40000004 0100500f 80007000 10101010 20202020 30303030 40404040
5
1 0 0badc0de
1 7 00004321
4 1 5 40000002 0100600f 80008000 feedface 0ddba11e
4 0 3 00000002 0100700f 80009000
4 1 3 40000000 0100800f 8000a000
5
2
0

/* verilog.f */
+incdir+include
rtl/bridge_pkg.sv
rtl/pcie_rx_filter.sv
rtl/snoop_cfg_regs.sv
rtl/tlp_snoop_framer.sv
rtl/pcie_eth_bridge.sv
verif/tb_pcie_eth_bridge.sv

/* Bender.yml */
package:
  name: pcie_eth_bridge

export_include_dirs:
  - include

sources:
  - rtl/bridge_pkg.sv
  - rtl/pcie_rx_filter.sv
  - rtl/snoop_cfg_regs.sv
  - rtl/tlp_snoop_framer.sv
  - rtl/pcie_eth_bridge.sv
  - target: test
    files:
      - verif/tb_pcie_eth_bridge.sv
